/* list.f */
rtl/cpu_bus_pkg.sv
rtl/lsu_ctrl_pkg.sv
rtl/segment_file.sv
rtl/load_store_unit.sv
rtl/word_memory.sv
rtl/mem_subsystem_top.sv
testbench/lsu_checker.sv
testbench/mem_subsystem_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compile and run the memory subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1
mkdir -p build
rm -f build/sim.log
verilator --binary --timing --assert -j 0 --top-module mem_subsystem_tb \
  -f list.f --Mdir build -o sim_mem_subsystem > build/compile.log 2>&1 \
  && ./build/sim_mem_subsystem > build/sim.log 2>&1 \
  || echo "Compile or simulation stopped early, see build/compile.log and build/sim.log"
[ -f build/sim.log ] && cat build/sim.log
grep -q "^RESULT: PASS$" build/sim.log 2>/dev/null \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

/* testbench/mem_subsystem_tb.sv */
// Testbench for the memory subsystem
// Stands in for the microcode side and compares every load with a
// byte-wide reference memory at segment*16 + offset

`timescale 1ns/1ps
`default_nettype none

module mem_subsystem_tb;

  localparam int REF_BYTES      = 2 << 12;  // Decoded memory size in bytes
  localparam int TIMEOUT_CYCLES = 200;

  logic                     clk = 1'b0;
  logic                     reset;
  lsu_ctrl_pkg::lsu_cmd_t   cmd;
  lsu_ctrl_pkg::seg_write_t seg_wr;
  logic [15:0]              mar_out;
  logic [15:0]              mdr_out;
  logic                     busy;
  cpu_bus_pkg::bus_req_t    bus_req;
  cpu_bus_pkg::bus_rsp_t    bus_rsp;

  logic [7:0]  ref_mem [REF_BYTES];
  bit          ref_valid [REF_BYTES];  // Byte written at least once
  logic [15:0] seg_val [4];
  int          errors;
  int          tests_passed;
  int          tests_failed;
  int          access_starts;
  int          last_periods;           // Access periods of the last order
  logic        access_prev = 1'b0;

  mem_subsystem_top dut0 (
    .clk         (clk),
    .reset       (reset),
    .cmd         (cmd),
    .seg_wr      (seg_wr),
    .mar_out     (mar_out),
    .mdr_out     (mdr_out),
    .busy        (busy),
    .bus_req_obs (bus_req),
    .bus_rsp_obs (bus_rsp)
  );

  always #2 clk = ~clk;

  always @(negedge clk) begin
    if (bus_req.access && !access_prev) access_starts++;  // Rising access
    access_prev = bus_req.access;
  end

  // ====================================================================
  // Reference model and checks
  // ====================================================================
  function automatic logic [19:0] phys_addr(input logic [1:0] sel, input logic [15:0] off);
    return {seg_val[sel], 4'h0} + {4'h0, off};
  endfunction

  function automatic int ref_idx(input logic [19:0] p);
    return int'(p) % REF_BYTES;  // Memory aliases above its size
  endfunction

  task automatic check_value(input string what, input logic [15:0] got,
                             input logic [15:0] exp, input logic [15:0] mask);
    assert (((got ^ exp) & mask) === 16'h0000) else begin
      $display("** Error at %0t ns: %s is %h, expected %h (mask %h)",
               $time, what, got, exp, mask);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int start_errors);
    if (errors == start_errors) begin
      tests_passed++;
      $display("[%0t ns] %s: passed", $time, name);
    end else begin
      tests_failed++;
      $display("[%0t ns] %s: failed, %0d errors", $time, name, errors - start_errors);
    end
  endtask

  // ====================================================================
  // Microcode side helpers that start and end on a falling edge
  // ====================================================================
  task automatic write_segment(input lsu_ctrl_pkg::seg_sel_t sel, input logic [15:0] data);
    seg_wr.en   = 1'b1;
    seg_wr.sel  = sel;
    seg_wr.data = data;
    @(negedge clk);
    seg_wr.en    = 1'b0;
    seg_val[sel] = data;
  endtask

  task automatic run_order(input logic wr, input lsu_ctrl_pkg::seg_sel_t sel,
                           input logic [15:0] off, input logic is_8bit,
                           input logic [15:0] data);
    int cycles;
    int start_count;
    cmd           = '0;
    cmd.write_mar = 1'b1;                  // MAR and MDR load one cycle before the order
    cmd.mar_in    = off;
    cmd.write_mdr = wr;
    cmd.mdr_in    = data;
    cmd.is_8bit   = is_8bit;
    cmd.seg_sel   = sel;
    @(negedge clk);
    cmd.write_mar = 1'b0;
    cmd.write_mdr = 1'b0;
    cmd.mem_write = wr;
    cmd.mem_read  = !wr;
    start_count   = access_starts;
    cycles        = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (busy && cycles < TIMEOUT_CYCLES);
    if (busy) begin
      $display("Timeout: busy stayed high for %0d cycles at offset %h", cycles, off);
      errors++;
    end
    last_periods  = access_starts - start_count;
    cmd.mem_read  = 1'b0;
    cmd.mem_write = 1'b0;
    @(negedge clk);                        // Unit steps back to idle
  endtask

  task automatic store(input lsu_ctrl_pkg::seg_sel_t sel, input logic [15:0] off,
                       input logic is_8bit, input logic [15:0] data);
    logic [19:0] p;
    p = phys_addr(sel, off);
    run_order(1'b1, sel, off, is_8bit, data);
    ref_mem[ref_idx(p)]   = data[7:0];     // Little-endian
    ref_valid[ref_idx(p)] = 1'b1;
    if (!is_8bit) begin
      ref_mem[ref_idx(p + 20'd1)]   = data[15:8];
      ref_valid[ref_idx(p + 20'd1)] = 1'b1;
    end
  endtask

  task automatic check_load(input lsu_ctrl_pkg::seg_sel_t sel, input logic [15:0] off,
                            input logic is_8bit, input string what,
                            output logic [15:0] got);
    int          lo;
    int          hi;
    logic [15:0] exp;
    logic [15:0] mask;
    lo   = ref_idx(phys_addr(sel, off));
    hi   = ref_idx(phys_addr(sel, off) + 20'd1);
    exp  = {8'h00, ref_mem[lo]};           // Byte loads are zero extended
    mask = {8'hFF, ref_valid[lo] ? 8'hFF : 8'h00};
    if (!is_8bit) begin
      exp[15:8]  = ref_mem[hi];
      mask[15:8] = ref_valid[hi] ? 8'hFF : 8'h00;
    end
    run_order(1'b0, sel, off, is_8bit, 16'h0000);
    got = mdr_out;
    check_value(what, got, exp, mask);
  endtask

  // ====================================================================
  // Tests
  // ====================================================================
  task automatic test_reset_state();
    int start;
    start = errors;
    check_value("busy after reset", 16'(busy), 16'h0000, 16'hFFFF);
    check_value("access after reset", 16'(bus_req.access), 16'h0000, 16'hFFFF);
    check_value("wr_en after reset", 16'(bus_req.wr_en), 16'h0000, 16'hFFFF);
    check_value("ack after reset", 16'(bus_rsp.ack), 16'h0000, 16'hFFFF);
    check_value("mar_out after reset", mar_out, 16'h0000, 16'hFFFF);
    report_test("reset state", start);
  endtask

  task automatic test_aligned();
    int          start;
    logic [15:0] got;
    start = errors;
    write_segment(lsu_ctrl_pkg::ds, 16'h0100);
    store(lsu_ctrl_pkg::ds, 16'h0020, 1'b0, 16'hA55A);
    store(lsu_ctrl_pkg::ds, 16'h0022, 1'b0, 16'h1234);
    check_load(lsu_ctrl_pkg::ds, 16'h0020, 1'b0, "aligned word", got);
    check_load(lsu_ctrl_pkg::ds, 16'h0022, 1'b0, "aligned word", got);
    store(lsu_ctrl_pkg::ds, 16'h0020, 1'b1, 16'hFFC3);
    check_load(lsu_ctrl_pkg::ds, 16'h0020, 1'b0, "word after byte write", got);
    check_load(lsu_ctrl_pkg::ds, 16'h0022, 1'b1, "aligned byte", got);
    report_test("aligned word and byte", start);
  endtask

  task automatic test_unaligned_word();
    int          start;
    logic [15:0] off;
    logic [15:0] got;
    start = errors;
    write_segment(lsu_ctrl_pkg::ss, 16'h0080);
    repeat (4) begin
      off = 16'($urandom_range(16'h0020, 16'h03FF)) | 16'h0001;
      store(lsu_ctrl_pkg::ss, off, 1'b0, 16'($urandom()));
      check_value("access periods of split store", 16'(last_periods), 16'd2, 16'hFFFF);
      check_load(lsu_ctrl_pkg::ss, off, 1'b0, "unaligned word", got);
      check_value("access periods of split load", 16'(last_periods), 16'd2, 16'hFFFF);
      check_load(lsu_ctrl_pkg::ss, off, 1'b1, "low byte of split word", got);
      check_load(lsu_ctrl_pkg::ss, off + 16'd1, 1'b1, "high byte of split word", got);
    end
    report_test("unaligned word", start);
  endtask

  task automatic test_unaligned_byte();
    int          start;
    logic [15:0] off;
    logic [15:0] got;
    start = errors;
    write_segment(lsu_ctrl_pkg::es, 16'h00C0);
    repeat (3) begin
      off = 16'($urandom_range(16'h0010, 16'h03FF)) | 16'h0001;
      store(lsu_ctrl_pkg::es, off - 16'd1, 1'b0, 16'($urandom()));
      store(lsu_ctrl_pkg::es, off + 16'd1, 1'b0, 16'($urandom()));
      store(lsu_ctrl_pkg::es, off, 1'b1, 16'($urandom()));
      check_value("access periods of odd byte", 16'(last_periods), 16'd1, 16'hFFFF);
      check_load(lsu_ctrl_pkg::es, off - 16'd1, 1'b0, "word holding odd byte", got);
      check_load(lsu_ctrl_pkg::es, off + 16'd1, 1'b0, "next word untouched", got);
      check_load(lsu_ctrl_pkg::es, off, 1'b1, "odd byte", got);
    end
    report_test("unaligned byte", start);
  endtask

  task automatic test_segments();
    int          start;
    logic [15:0] data;
    logic [15:0] got_es;
    logic [15:0] got_ss;
    start = errors;
    data  = 16'($urandom());
    write_segment(lsu_ctrl_pkg::es, 16'h0120);
    write_segment(lsu_ctrl_pkg::ss, 16'h0100);
    store(lsu_ctrl_pkg::es, 16'h0050, 1'b0, data);                // Physical 0x01250
    check_load(lsu_ctrl_pkg::ss, 16'h0250, 1'b0, "read through ss", got_ss);
    check_value("same physical address", got_ss, data, 16'hFFFF);
    store(lsu_ctrl_pkg::es, 16'h0010, 1'b0, data);
    store(lsu_ctrl_pkg::ss, 16'h0010, 1'b0, ~data);
    check_load(lsu_ctrl_pkg::es, 16'h0010, 1'b0, "es:0010", got_es);
    check_load(lsu_ctrl_pkg::ss, 16'h0010, 1'b0, "ss:0010", got_ss);
    assert (got_es !== got_ss) else begin
      $display("** Error at %0t ns: es and ss at one offset read the same %h", $time, got_es);
      errors++;
    end
    report_test("segment arithmetic", start);
  endtask

  task automatic test_random_mix();
    int                     start;
    int                     k;
    lsu_ctrl_pkg::seg_sel_t sel;
    logic [15:0]            off;
    logic                   is_8bit;
    logic [15:0]            got;
    lsu_ctrl_pkg::seg_sel_t stored_sel [$];  // Places written so far, revisited by loads
    logic [15:0]            stored_off [$];
    start = errors;
    for (int s = 0; s < 4; s++) begin
      write_segment(lsu_ctrl_pkg::seg_sel_t'(s), 16'h0100 + 16'($urandom_range(0, 255)));
    end
    repeat (40) begin
      sel     = lsu_ctrl_pkg::seg_sel_t'(2'($urandom_range(0, 3)));
      off     = 16'($urandom_range(0, 16'h01FF));
      is_8bit = 1'($urandom_range(0, 1));
      if (stored_off.size() == 0 || $urandom_range(0, 99) < 55) begin
        store(sel, off, is_8bit, 16'($urandom()));
        stored_sel.push_back(sel);
        stored_off.push_back(off);
      end else begin
        k = int'($urandom_range(0, stored_off.size() - 1));
        check_load(stored_sel[k], stored_off[k], is_8bit, "random load", got);
      end
    end
    report_test("random mixed accesses", start);
  endtask

  initial begin
    cmd    = '0;
    seg_wr = '0;
    reset  = 1'b1;
    void'($urandom(23));
    repeat (10) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    test_reset_state();
    test_aligned();
    test_unaligned_word();
    test_unaligned_byte();
    test_segments();
    test_random_mix();
    $display("Tests passed %0d, failed %0d, check errors %0d",
             tests_passed, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule : mem_subsystem_tb

`default_nettype wire

/* testbench/lsu_checker.sv */
// Bus protocol checker for the load/store unit
// Watches the access/ack handshake on the memory bus, bound into
// every load_store_unit instance

`timescale 1ns/1ps
`default_nettype none

module lsu_checker (
  input logic                  clk,
  input logic                  reset,
  input cpu_bus_pkg::bus_req_t bus_req,
  input cpu_bus_pkg::bus_rsp_t bus_rsp
);

  // Request held steady while the memory counts its wait states
  access_held: assert property (@(posedge clk) disable iff (reset)
    bus_req.access && !bus_rsp.ack |=> bus_req.access && $stable(bus_req.addr))
    else $error("access dropped or address moved before ack");

  access_drop: assert property (@(posedge clk) disable iff (reset)
    bus_rsp.ack |=> !bus_req.access)
    else $error("access still high in the cycle after ack");

  write_needs_access: assert property (@(posedge clk) disable iff (reset)
    bus_req.wr_en |-> bus_req.access)
    else $error("wr_en high without access");

  lanes_selected: assert property (@(posedge clk) disable iff (reset)
    bus_req.access |-> bus_req.bytesel != 2'b00)
    else $error("access high with no byte lane selected");

endmodule : lsu_checker

bind load_store_unit lsu_checker checker0 (
  .clk     (clk),
  .reset   (reset),
  .bus_req (bus_req),
  .bus_rsp (bus_rsp)
);

`default_nettype wire

/* rtl/mem_subsystem_top.sv */
// Memory subsystem top level
// Segment register file, load/store unit and memory model joined on the
// 16-bit bus. The bus bundles are brought out for observation

`timescale 1ns/1ps
`default_nettype none

module mem_subsystem_top #(
  parameter int unsigned WAIT_STATES    = 2,
  parameter int unsigned MEM_WORDS_LOG2 = 12
) (
  input  logic                     clk,
  input  logic                     reset,
  input  lsu_ctrl_pkg::lsu_cmd_t   cmd,
  input  lsu_ctrl_pkg::seg_write_t seg_wr,
  output logic [15:0]              mar_out,
  output logic [15:0]              mdr_out,
  output logic                     busy,
  output cpu_bus_pkg::bus_req_t    bus_req_obs,
  output cpu_bus_pkg::bus_rsp_t    bus_rsp_obs
);

  logic [15:0] segment;  // Selected segment, combinational

  segment_file seg_file0 (
    .clk     (clk),
    .reset   (reset),
    .seg_wr  (seg_wr),
    .seg_sel (cmd.seg_sel),
    .segment (segment)
  );

  load_store_unit lsu0 (
    .clk     (clk),
    .reset   (reset),
    .cmd     (cmd),
    .segment (segment),
    .bus_req (bus_req_obs),  // Bus nets double as observation ports
    .bus_rsp (bus_rsp_obs),
    .mar_out (mar_out),
    .mdr_out (mdr_out),
    .busy    (busy)
  );

  word_memory #(
    .WAIT_STATES    (WAIT_STATES),
    .MEM_WORDS_LOG2 (MEM_WORDS_LOG2)
  ) mem0 (
    .clk     (clk),
    .reset   (reset),
    .bus_req (bus_req_obs),
    .bus_rsp (bus_rsp_obs)
  );

endmodule : mem_subsystem_top

`default_nettype wire

/* rtl/word_memory.sv */
// Word-organized memory model
// Answers the 16-bit bus after WAIT_STATES extra cycles with a one-cycle
// ack. Writes touch only the selected byte lanes, reads return the word.
// Only the low MEM_WORDS_LOG2 word address bits are decoded

`timescale 1ns/1ps
`default_nettype none

module word_memory #(
  parameter int unsigned WAIT_STATES    = 2,   // 0 to 7
  parameter int unsigned MEM_WORDS_LOG2 = 12
) (
  input  logic                  clk,
  input  logic                  reset,
  input  cpu_bus_pkg::bus_req_t bus_req,
  output cpu_bus_pkg::bus_rsp_t bus_rsp
);

  localparam int unsigned DEPTH = 1 << MEM_WORDS_LOG2;

  logic [15:0]               mem [DEPTH];
  logic [MEM_WORDS_LOG2-1:0] idx;
  logic [2:0]                wait_cnt;
  logic                      ack_r;
  logic [15:0]               rdata_r;
  logic                      fire;

  assign idx  = bus_req.addr[MEM_WORDS_LOG2:1];  // Upper bits alias
  // Last wait cycle of an access, no restart during the ack cycle itself
  assign fire = bus_req.access && !ack_r && (wait_cnt == 3'(WAIT_STATES));

  // ====================================================================
  // Wait-state counter and ack
  // ====================================================================
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wait_cnt <= 3'd0;
      ack_r    <= 1'b0;
    end else begin
      ack_r <= fire;
      if (fire || !bus_req.access) begin
        wait_cnt <= 3'd0;
      end else if (!ack_r) begin
        wait_cnt <= wait_cnt + 3'd1;
      end
    end
  end

  // ====================================================================
  // Storage
  // ====================================================================
  always_ff @(posedge clk) begin
    if (fire) begin
      rdata_r <= mem[idx];
      if (bus_req.wr_en && bus_req.bytesel[0]) mem[idx][7:0]  <= bus_req.wdata[7:0];
      if (bus_req.wr_en && bus_req.bytesel[1]) mem[idx][15:8] <= bus_req.wdata[15:8];
    end
  end

  assign bus_rsp.rdata = rdata_r;
  assign bus_rsp.ack   = ack_r;

endmodule : word_memory

`default_nettype wire

/* rtl/load_store_unit.sv */
// Load/store unit
// Holds MAR and MDR, forms the physical address segment*16 + offset and
// runs the memory bus. Unaligned words are split into two byte
// transactions, one per neighbouring word. busy stalls the microcode
// until the order has completed

`timescale 1ns/1ps
`default_nettype none

module load_store_unit (
  input  logic                   clk,
  input  logic                   reset,
  input  lsu_ctrl_pkg::lsu_cmd_t cmd,
  input  logic [15:0]            segment,
  output cpu_bus_pkg::bus_req_t  bus_req,
  input  cpu_bus_pkg::bus_rsp_t  bus_rsp,
  output logic [15:0]            mar_out,
  output logic [15:0]            mdr_out,
  output logic                   busy
);

  typedef enum logic [2:0] {
    st_idle,
    st_first,        // Raise access for the first (or only) transaction
    st_wait_first,
    st_second,       // Split word, low lane of the next word
    st_wait_second,
    st_complete_op,
    st_clear
  } state_t;

  state_t      state;
  logic [15:0] mar;
  logic [15:0] mdr;
  logic        complete;

  logic        request;
  logic        unaligned;
  logic        split;
  logic [18:0] word_addr;

  // ====================================================================
  // Order decode and address calculation
  // ====================================================================
  assign request   = cmd.mem_read | cmd.mem_write;
  assign unaligned = mar[0];
  assign split     = unaligned & ~cmd.is_8bit;  // Unaligned word needs two trips

  // Segment*8 + offset/2 gives the word address, wraps at 1 MB
  assign word_addr = {segment, 3'b000} + {4'b0000, mar[15:1]};

  assign busy = request & ~complete;

  // ====================================================================
  // Memory address register
  // ====================================================================
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      mar <= 16'h0000;
    end else if (cmd.write_mar) begin
      mar <= cmd.mar_in;
    end
  end

  // ====================================================================
  // Bus sequencing FSM
  // ====================================================================
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state    <= st_idle;
      complete <= 1'b0;
      bus_req  <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (request) begin
            bus_req.addr <= word_addr;
            state        <= st_first;
          end
        end

        st_first: begin
          bus_req.access <= 1'b1;
          bus_req.wr_en  <= cmd.mem_write;
          if (unaligned) begin
            // Odd byte sits in the high lane of its word
            bus_req.bytesel <= 2'b10;
            bus_req.wdata   <= {mdr[7:0], 8'h00};
          end else begin
            bus_req.bytesel <= cmd.is_8bit ? 2'b01 : 2'b11;
            bus_req.wdata   <= mdr;
          end
          state <= st_wait_first;
        end

        st_wait_first: begin
          if (bus_rsp.ack) begin
            bus_req.access <= 1'b0;
            bus_req.wr_en  <= 1'b0;
            if (split) begin
              bus_req.addr <= bus_req.addr + 19'd1;  // Next word holds the high byte
              state        <= st_second;
            end else begin
              complete      <= 1'b1;
              bus_req.addr  <= '0;                   // Keep the bus quiet
              bus_req.wdata <= 16'h0000;
              state         <= st_complete_op;
            end
          end
        end

        st_second: begin
          bus_req.access  <= 1'b1;
          bus_req.wr_en   <= cmd.mem_write;
          bus_req.bytesel <= 2'b01;
          bus_req.wdata   <= {8'h00, mdr[15:8]};
          state           <= st_wait_second;
        end

        st_wait_second: begin
          if (bus_rsp.ack) begin
            bus_req.access <= 1'b0;
            bus_req.wr_en  <= 1'b0;
            complete       <= 1'b1;
            bus_req.addr   <= '0;
            bus_req.wdata  <= 16'h0000;
            state          <= st_complete_op;
          end
        end

        // busy is already low here, microcode drops its order
        st_complete_op: begin
          bus_req.bytesel <= 2'b00;
          state           <= st_clear;
        end

        st_clear: begin
          complete <= 1'b0;
          state    <= st_idle;
        end

        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // ====================================================================
  // Memory data register
  // ====================================================================
  // Bus data is taken in the ack cycle of a read, else loaded by microcode
  always_ff @(posedge clk) begin
    if (bus_rsp.ack && cmd.mem_read && state == st_wait_first) begin
      if (split) begin
        mdr[7:0] <= bus_rsp.rdata[15:8];            // First half of a split word
      end else if (unaligned) begin
        mdr <= {8'h00, bus_rsp.rdata[15:8]};
      end else if (cmd.is_8bit) begin
        mdr <= {8'h00, bus_rsp.rdata[7:0]};         // Zero extended
      end else begin
        mdr <= bus_rsp.rdata;
      end
    end else if (bus_rsp.ack && cmd.mem_read && state == st_wait_second) begin
      mdr[15:8] <= bus_rsp.rdata[7:0];
    end else if (cmd.write_mdr) begin
      mdr <= cmd.mdr_in;
    end
  end

  assign mar_out = mar;
  assign mdr_out = mdr;

endmodule : load_store_unit

`default_nettype wire

/* rtl/segment_file.sv */
// Segment register file
// Holds es, cs, ss and ds. One synchronous write port, one combinational
// read port that feeds the physical address adder

`timescale 1ns/1ps
`default_nettype none

module segment_file (
  input  logic                     clk,
  input  logic                     reset,
  input  lsu_ctrl_pkg::seg_write_t seg_wr,
  input  lsu_ctrl_pkg::seg_sel_t   seg_sel,
  output logic [15:0]              segment
);

  // Indexed by the seg_sel_t encoding
  logic [15:0] seg_regs [4];

  // ====================================================================
  // Write port
  // ====================================================================
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < 4; i++) begin
        seg_regs[i] <= 16'h0000;
      end
    end else if (seg_wr.en) begin
      seg_regs[seg_wr.sel] <= seg_wr.data;  // Seen on the read port next cycle
    end
  end

  // ====================================================================
  // Read port
  // ====================================================================
  always_comb begin
    segment = seg_regs[seg_sel];
  end

endmodule : segment_file

`default_nettype wire

/* rtl/lsu_ctrl_pkg.sv */
// Load/store control definitions
// Segment selection, segment register writes and the order word that
// the microcode side hands to the load/store unit

`default_nettype none

package lsu_ctrl_pkg;

  // x86 segment register encoding
  typedef enum logic [1:0] {
    es = 2'd0,
    cs = 2'd1,
    ss = 2'd2,
    ds = 2'd3
  } seg_sel_t;

  // Write port of the segment register file
  typedef struct packed {
    logic        en;
    seg_sel_t    sel;
    logic [15:0] data;
  } seg_write_t;

  // Microcode orders, held as levels
  typedef struct packed {
    logic        write_mar;
    logic [15:0] mar_in;
    logic        write_mdr;
    logic [15:0] mdr_in;
    logic        mem_read;   // Held until busy falls
    logic        mem_write;  // Never together with mem_read
    logic        is_8bit;    // Byte access, else word
    seg_sel_t    seg_sel;
  } lsu_cmd_t;

endpackage : lsu_ctrl_pkg

`default_nettype wire

/* rtl/cpu_bus_pkg.sv */
// CPU memory bus definitions
// Request and response bundles for the 16-bit data bus with byte selects
// that runs between the load/store unit and the memory

`default_nettype none

package cpu_bus_pkg;

  // Master to memory. Everything is held steady from access up to ack
  typedef struct packed {
    logic [19:1] addr;     // Word address, physical bits 19 to 1
    logic [15:0] wdata;
    logic        wr_en;
    logic [1:0]  bytesel;  // Bit 0 low byte (even), bit 1 high byte (odd)
    logic        access;
  } bus_req_t;

  // Memory to master
  typedef struct packed {
    logic [15:0] rdata;    // Valid in the ack cycle of a read
    logic        ack;      // One cycle pulse
  } bus_rsp_t;

endpackage : cpu_bus_pkg

`default_nettype wire
